// File: rtl/serial_bus_pkg.sv
// serial bus package: bus widths, opcodes, command struct and bus line structs
package serial_bus_pkg;

	// slave select width, one bit for two slaves
	localparam int slave_len = 1;
	// byte address into each slave memory
	localparam int addr_len = 12;
	localparam int data_len = 8;

	// opcodes 0 and 1 are idle
	localparam logic [1:0] op_write = 2'd2;
	localparam logic [1:0] op_read = 2'd3;

	// host command, held stable while cmd_req is high
	typedef struct packed {
		logic [1:0] op;
		logic [slave_len-1:0] slave;
		logic [addr_len-1:0] addr;
		logic [data_len-1:0] wdata;
	} cmd_t;

	// lines driven by the granted master
	typedef struct packed {
		logic sel_bit;
		logic addr_bit;
		logic data_bit;
		logic master_valid;
		logic master_ready;
		logic write_en;
		logic read_en;
	} mst_bus_t;

	// lines driven by a slave, or-ed on the way back
	typedef struct packed {
		logic rx_data;
		logic slave_valid;
		logic slave_ready;
	} slv_bus_t;

endpackage

// File: rtl/master_out_port.sv
// master out port: bus request FSM and serial transmit of select, address and write data
module master_out_port (
	input  logic clk,
	input  logic arst_n,
	input  logic start,
	input  serial_bus_pkg::cmd_t cmd,
	input  logic grant,
	input  logic slave_ready,
	input  logic rx_done,
	output logic approval_request,
	output logic tx_done,
	output logic sel_bit,
	output logic addr_bit,
	output logic data_bit,
	output logic master_valid,
	output logic write_en,
	output logic read_en
);

	typedef enum logic [2:0] {
		st_idle,
		st_request,
		st_select,
		st_address,
		st_wait_ready,
		st_data,
		st_release
	} state_t;

	state_t state;
	// counts bits within the current field
	logic [$clog2(serial_bus_pkg::addr_len)-1:0] cnt;
	// whole frame, select bits at the low end, shifted right per sent bit
	logic [serial_bus_pkg::data_len+serial_bus_pkg::addr_len+serial_bus_pkg::slave_len-1:0] frame_sr;
	logic is_read;
	logic load;
	logic in_frame;
	logic last_sel;
	logic last_addr;
	logic last_data;

	// new command taken from idle, or straight from release once the grant is gone
	assign load = start && (state == st_idle || (state == st_release && !grant));

	assign last_sel = (state == st_select) && (cnt == serial_bus_pkg::slave_len - 1);
	assign last_addr = (state == st_address) && (cnt == serial_bus_pkg::addr_len - 1);
	assign last_data = (state == st_data) && (cnt == serial_bus_pkg::data_len - 1);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			cnt <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (load)
						state <= st_request;
				end
				st_request: begin
					cnt <= '0;
					if (grant)
						state <= st_select;
				end
				st_select: begin
					if (last_sel) begin
						state <= st_address;
						cnt <= '0;
					end else
						cnt <= cnt + 1'b1;
				end
				st_address: begin
					if (last_addr) begin
						state <= st_wait_ready;
						cnt <= '0;
					end else
						cnt <= cnt + 1'b1;
				end
				// read waits for the in port, write waits for the slave
				st_wait_ready: begin
					if (is_read) begin
						if (rx_done)
							state <= st_release;
					end else if (slave_ready)
						state <= st_data;
				end
				st_data: begin
					if (last_data)
						state <= st_release;
					else
						cnt <= cnt + 1'b1;
				end
				// request is down, wait for the arbiter to free the bus
				st_release: begin
					if (!grant)
						state <= load ? st_request : st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			frame_sr <= {cmd.wdata, cmd.addr, cmd.slave};
			is_read <= (cmd.op == serial_bus_pkg::op_read);
		end else if (master_valid)
			frame_sr <= frame_sr >> 1;
	end

	assign approval_request = state inside {st_request, st_select, st_address, st_wait_ready,
		st_data};
	assign in_frame = state inside {st_select, st_address, st_wait_ready, st_data};
	assign master_valid = state inside {st_select, st_address, st_data};

	// one line per field, lsb first
	assign sel_bit = (state == st_select) && frame_sr[0];
	assign addr_bit = (state == st_address) && frame_sr[0];
	assign data_bit = (state == st_data) && frame_sr[0];

	assign write_en = in_frame && !is_read;
	assign read_en = in_frame && is_read;

	// read ends transmit at the last address bit
	assign tx_done = (last_addr && is_read) || last_data;

endmodule

// File: rtl/master_in_port.sv
// master in port: serial receive of read data with master_ready and read_en
module master_in_port (
	input  logic clk,
	input  logic arst_n,
	input  logic rd_start,
	input  logic rx_data,
	input  logic slave_valid,
	output logic master_ready,
	output logic read_en,
	output logic [serial_bus_pkg::data_len-1:0] rdata,
	output logic rx_done
);

	logic receiving;
	logic [$clog2(serial_bus_pkg::data_len)-1:0] cnt;
	logic last_bit;

	assign last_bit = receiving && slave_valid && (cnt == serial_bus_pkg::data_len - 1);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			receiving <= 1'b0;
			cnt <= '0;
			rx_done <= 1'b0;
		end else begin
			// single cycle pulse
			rx_done <= last_bit;
			if (rd_start) begin
				receiving <= 1'b1;
				cnt <= '0;
			end else if (last_bit)
				receiving <= 1'b0;
			else if (receiving && slave_valid)
				cnt <= cnt + 1'b1;
		end
	end

	// lsb arrives first and ends up at bit 0
	always_ff @(posedge clk) begin
		if (receiving && slave_valid)
			rdata <= {rx_data, rdata[serial_bus_pkg::data_len-1:1]};
	end

	// both held for the whole receive
	assign master_ready = receiving;
	assign read_en = receiving;

endmodule

// File: rtl/master_port.sv
// master port: host req/ack handshake, in and out ports, bus line merge and read data return
module master_port (
	input  logic clk,
	input  logic arst_n,
	input  logic cmd_req,
	input  serial_bus_pkg::cmd_t cmd,
	output logic cmd_ack,
	output logic [serial_bus_pkg::data_len-1:0] rdata,
	input  logic grant,
	output logic approval_request,
	input  serial_bus_pkg::slv_bus_t sbus,
	output serial_bus_pkg::mst_bus_t mbus
);

	typedef enum logic [1:0] {
		mp_idle,
		mp_busy,
		mp_ack
	} state_t;

	state_t state;
	serial_bus_pkg::slv_bus_t sbus_g;
	logic is_bus_op;
	logic start;
	logic done;
	logic tx_done;
	logic rx_done;
	logic rd_start;
	logic sel_bit;
	logic addr_bit;
	logic data_bit;
	logic master_valid;
	logic write_en;
	logic read_en_out;
	logic read_en_in;
	logic master_ready;

	assign is_bus_op = (cmd.op == serial_bus_pkg::op_write) ||
		(cmd.op == serial_bus_pkg::op_read);
	// grant still high means the previous frame is being released
	assign start = (state == mp_idle) && cmd_req && is_bus_op && !grant;
	assign done = (cmd.op == serial_bus_pkg::op_read) ? rx_done : tx_done;
	assign rd_start = tx_done && (cmd.op == serial_bus_pkg::op_read);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			state <= mp_idle;
		else begin
			case (state)
				mp_idle: begin
					// idle opcode acked without touching the bus
					if (cmd_req && !is_bus_op)
						state <= mp_ack;
					else if (start)
						state <= mp_busy;
				end
				mp_busy: begin
					if (done)
						state <= mp_ack;
				end
				mp_ack: begin
					if (!cmd_req)
						state <= mp_idle;
				end
				default: state <= mp_idle;
			endcase
		end
	end

	assign cmd_ack = (state == mp_ack);

	// return lines only count while this master owns the bus
	always_comb begin
		sbus_g = '0;
		if (grant)
			sbus_g = sbus;
	end

	master_out_port master_out_port_i (
		.clk(clk),
		.arst_n(arst_n),
		.start(start),
		.cmd(cmd),
		.grant(grant),
		.slave_ready(sbus_g.slave_ready),
		.rx_done(rx_done),
		.approval_request(approval_request),
		.tx_done(tx_done),
		.sel_bit(sel_bit),
		.addr_bit(addr_bit),
		.data_bit(data_bit),
		.master_valid(master_valid),
		.write_en(write_en),
		.read_en(read_en_out)
	);

	master_in_port master_in_port_i (
		.clk(clk),
		.arst_n(arst_n),
		.rd_start(rd_start),
		.rx_data(sbus_g.rx_data),
		.slave_valid(sbus_g.slave_valid),
		.master_ready(master_ready),
		.read_en(read_en_in),
		.rdata(rdata),
		.rx_done(rx_done)
	);

	// read_en spans both ports, so it stays up from select to last read bit
	assign mbus = '{
		sel_bit: sel_bit,
		addr_bit: addr_bit,
		data_bit: data_bit,
		master_valid: master_valid,
		master_ready: master_ready,
		write_en: write_en,
		read_en: read_en_out | read_en_in
	};

endmodule

// File: rtl/bus_arbiter.sv
// bus arbiter: round-robin grant for two masters, master line mux and slave return or
module bus_arbiter (
	input  logic clk,
	input  logic arst_n,
	input  logic request_0,
	input  logic request_1,
	output logic grant_0,
	output logic grant_1,
	input  serial_bus_pkg::mst_bus_t mbus_0,
	input  serial_bus_pkg::mst_bus_t mbus_1,
	output serial_bus_pkg::mst_bus_t mbus,
	input  serial_bus_pkg::slv_bus_t sbus_0,
	input  serial_bus_pkg::slv_bus_t sbus_1,
	output serial_bus_pkg::slv_bus_t sbus
);

	logic [1:0] grant_q;
	// index of the master granted last
	logic last_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			grant_q <= 2'b00;
			last_q <= 1'b1;
		end else if (grant_q == 2'b00) begin
			// master 0 wins unless it went last and master 1 waits
			if (request_0 && (!request_1 || last_q)) begin
				grant_q <= 2'b01;
				last_q <= 1'b0;
			end else if (request_1) begin
				grant_q <= 2'b10;
				last_q <= 1'b1;
			end
		end else if ((grant_q[0] && !request_0) || (grant_q[1] && !request_1))
			grant_q <= 2'b00;
	end

	assign grant_0 = grant_q[0];
	assign grant_1 = grant_q[1];

	// bus reads zero with no owner
	always_comb begin
		mbus = '0;
		if (grant_q[0])
			mbus = mbus_0;
		else if (grant_q[1])
			mbus = mbus_1;
	end

	// unselected slave drives zeros
	assign sbus = sbus_0 | sbus_1;

endmodule

// File: rtl/slave_port.sv
// slave port: select match, address and data deserialise, byte memory and read data serialise
module slave_port #(
	parameter int slave_id = 0
) (
	input  logic clk,
	input  logic arst_n,
	input  serial_bus_pkg::mst_bus_t mbus,
	output serial_bus_pkg::slv_bus_t sbus
);

	typedef enum logic [2:0] {
		sl_select,
		sl_address,
		sl_wdata,
		sl_send,
		sl_done
	} state_t;

	state_t state;
	logic [$clog2(serial_bus_pkg::addr_len)-1:0] cnt;
	logic match;
	logic ready_q;
	logic valid_q;
	logic tx_bit;
	logic [serial_bus_pkg::slave_len-1:0] sel_sr;
	logic [serial_bus_pkg::slave_len-1:0] sel_next;
	logic [serial_bus_pkg::addr_len-1:0] addr_sr;
	logic [serial_bus_pkg::addr_len-1:0] addr_next;
	logic [serial_bus_pkg::data_len-1:0] data_sr;
	logic [serial_bus_pkg::data_len-1:0] data_next;
	logic [serial_bus_pkg::data_len-1:0] rd_buf;
	logic [serial_bus_pkg::data_len-1:0] mem [2**serial_bus_pkg::addr_len];
	logic active;
	logic bit_in;
	logic last_sel;
	logic last_addr;
	logic last_data;
	logic sending;

	assign active = mbus.write_en || mbus.read_en;
	assign bit_in = active && mbus.master_valid;
	assign last_sel = bit_in && (state == sl_select) &&
		(cnt == serial_bus_pkg::slave_len - 1);
	assign last_addr = bit_in && (state == sl_address) &&
		(cnt == serial_bus_pkg::addr_len - 1);
	assign last_data = bit_in && (state == sl_wdata) &&
		(cnt == serial_bus_pkg::data_len - 1);
	assign sending = (state == sl_send) && mbus.master_ready;

	// shift registers with the incoming bit at the top, lsb first on the wire
	always_comb begin
		sel_next = sel_sr >> 1;
		sel_next[serial_bus_pkg::slave_len-1] = mbus.sel_bit;
		addr_next = addr_sr >> 1;
		addr_next[serial_bus_pkg::addr_len-1] = mbus.addr_bit;
		data_next = data_sr >> 1;
		data_next[serial_bus_pkg::data_len-1] = mbus.data_bit;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= sl_select;
			cnt <= '0;
			match <= 1'b0;
			ready_q <= 1'b0;
			valid_q <= 1'b0;
			tx_bit <= 1'b0;
		end else if (!active) begin
			// enables down, frame over
			state <= sl_select;
			cnt <= '0;
			match <= 1'b0;
			ready_q <= 1'b0;
			valid_q <= 1'b0;
			tx_bit <= 1'b0;
		end else begin
			case (state)
				sl_select: begin
					if (last_sel) begin
						state <= sl_address;
						cnt <= '0;
						match <= (int'(sel_next) == slave_id);
					end else if (bit_in)
						cnt <= cnt + 1'b1;
				end
				sl_address: begin
					if (last_addr) begin
						cnt <= '0;
						// ready one cycle after the last address bit
						ready_q <= match;
						state <= mbus.read_en ? sl_send : sl_wdata;
					end else if (bit_in)
						cnt <= cnt + 1'b1;
				end
				sl_wdata: begin
					if (last_data)
						state <= sl_done;
					else if (bit_in)
						cnt <= cnt + 1'b1;
				end
				// first read bit once the master is listening
				sl_send: begin
					if (sending) begin
						tx_bit <= match && rd_buf[0];
						valid_q <= match;
						if (cnt == serial_bus_pkg::data_len - 1)
							state <= sl_done;
						else
							cnt <= cnt + 1'b1;
					end else
						valid_q <= 1'b0;
				end
				sl_done: begin
					valid_q <= 1'b0;
					tx_bit <= 1'b0;
				end
				default: state <= sl_select;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (bit_in) begin
			case (state)
				sl_select: sel_sr <= sel_next;
				sl_address: addr_sr <= addr_next;
				sl_wdata: data_sr <= data_next;
				default: ;
			endcase
		end
		// byte lands with its last bit
		if (last_data && match)
			mem[addr_sr] <= data_next;
		// read byte fetched as the address completes
		if (last_addr)
			rd_buf <= mem[addr_next];
		else if (sending)
			rd_buf <= rd_buf >> 1;
	end

	assign sbus = '{rx_data: tx_bit, slave_valid: valid_q, slave_ready: ready_q};

endmodule

// File: rtl/serial_bus_top.sv
// serial bus top: two master ports, the arbiter and two slave ports
module serial_bus_top (
	input  logic clk,
	input  logic arst_n,
	input  logic cmd_req_0,
	input  logic cmd_req_1,
	input  serial_bus_pkg::cmd_t cmd_0,
	input  serial_bus_pkg::cmd_t cmd_1,
	output logic cmd_ack_0,
	output logic cmd_ack_1,
	output logic [serial_bus_pkg::data_len-1:0] rdata_0,
	output logic [serial_bus_pkg::data_len-1:0] rdata_1
);

	logic request_0;
	logic request_1;
	logic grant_0;
	logic grant_1;
	// per master lines and the shared copy after the mux
	serial_bus_pkg::mst_bus_t mbus_0;
	serial_bus_pkg::mst_bus_t mbus_1;
	serial_bus_pkg::mst_bus_t mbus;
	// per slave returns and their or
	serial_bus_pkg::slv_bus_t sbus_0;
	serial_bus_pkg::slv_bus_t sbus_1;
	serial_bus_pkg::slv_bus_t sbus;

	master_port master_port_0 (
		.clk(clk),
		.arst_n(arst_n),
		.cmd_req(cmd_req_0),
		.cmd(cmd_0),
		.cmd_ack(cmd_ack_0),
		.rdata(rdata_0),
		.grant(grant_0),
		.approval_request(request_0),
		.sbus(sbus),
		.mbus(mbus_0)
	);

	master_port master_port_1 (
		.clk(clk),
		.arst_n(arst_n),
		.cmd_req(cmd_req_1),
		.cmd(cmd_1),
		.cmd_ack(cmd_ack_1),
		.rdata(rdata_1),
		.grant(grant_1),
		.approval_request(request_1),
		.sbus(sbus),
		.mbus(mbus_1)
	);

	bus_arbiter bus_arbiter_i (
		.clk(clk),
		.arst_n(arst_n),
		.request_0(request_0),
		.request_1(request_1),
		.grant_0(grant_0),
		.grant_1(grant_1),
		.mbus_0(mbus_0),
		.mbus_1(mbus_1),
		.mbus(mbus),
		.sbus_0(sbus_0),
		.sbus_1(sbus_1),
		.sbus(sbus)
	);

	slave_port #(.slave_id(0)) slave_port_0 (
		.clk(clk),
		.arst_n(arst_n),
		.mbus(mbus),
		.sbus(sbus_0)
	);

	slave_port #(.slave_id(1)) slave_port_1 (
		.clk(clk),
		.arst_n(arst_n),
		.mbus(mbus),
		.sbus(sbus_1)
	);

endmodule

// File: verification/serial_bus_tasks.svh
// testbench tasks: xorshift, value check, host handshake and directed tests
function automatic logic [31:0] xorshift();
	logic [31:0] x;
	x = rng_state;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	rng_state = x;
	return x;
endfunction

task automatic check_eq(input string name, input logic [31:0] expected,
	input logic [31:0] actual);
	checks++;
	if (actual !== expected) begin
		errors++;
		$display("[FAIL] t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
	end
endtask

function automatic serial_bus_pkg::cmd_t make_cmd(input logic [1:0] op,
	input logic [serial_bus_pkg::slave_len-1:0] slave,
	input logic [serial_bus_pkg::addr_len-1:0] addr,
	input logic [serial_bus_pkg::data_len-1:0] wdata);
	serial_bus_pkg::cmd_t c;
	c.op = op;
	c.slave = slave;
	c.addr = addr;
	c.wdata = wdata;
	return c;
endfunction

// host lines of one master
task automatic drive_master(input int m, input logic req, input serial_bus_pkg::cmd_t c);
	if (m == 0) begin
		cmd_req_0 = req;
		cmd_0 = c;
	end else begin
		cmd_req_1 = req;
		cmd_1 = c;
	end
endtask

function automatic logic ack_of(input int m);
	return (m == 0) ? cmd_ack_0 : cmd_ack_1;
endfunction

function automatic logic [serial_bus_pkg::data_len-1:0] rdata_of(input int m);
	return (m == 0) ? rdata_0 : rdata_1;
endfunction

// one four-phase exchange, model checked or updated at cmd_ack
task automatic issue_cmd(input int m, input serial_bus_pkg::cmd_t c);
	logic [key_len-1:0] key;
	key = {c.slave, c.addr};
	@(posedge clk);
	#2;
	drive_master(m, 1'b1, c);
	do begin
		@(posedge clk);
		#2;
	end while (!ack_of(m));
	if (c.op == serial_bus_pkg::op_read) begin
		if (model.exists(key))
			check_eq($sformatf("rdata_%0d", m), model[key], rdata_of(m));
		else begin
			errors++;
			$display("read of slave %0d address %0h came before any write to it",
				c.slave, c.addr);
		end
	end else if (c.op == serial_bus_pkg::op_write)
		model[key] = c.wdata;
	// ack holds while req is still up
	@(posedge clk);
	#2;
	check_eq($sformatf("cmd_ack_%0d", m), 1, ack_of(m));
	drive_master(m, 1'b0, c);
	do begin
		@(posedge clk);
		#2;
	end while (ack_of(m));
endtask

task automatic after_reset_test();
	check_eq("cmd_ack_0", 0, cmd_ack_0);
	check_eq("cmd_ack_1", 0, cmd_ack_1);
	issue_cmd(0, make_cmd(serial_bus_pkg::op_write, 1'b0, 12'h123, 8'h5e));
	issue_cmd(0, make_cmd(serial_bus_pkg::op_read, 1'b0, 12'h123, 8'h00));
endtask

// same address, different byte per slave
task automatic select_decode_test();
	issue_cmd(1, make_cmd(serial_bus_pkg::op_write, 1'b0, 12'h055, 8'ha5));
	issue_cmd(1, make_cmd(serial_bus_pkg::op_write, 1'b1, 12'h055, 8'h5a));
	issue_cmd(0, make_cmd(serial_bus_pkg::op_read, 1'b0, 12'h055, 8'h00));
	issue_cmd(0, make_cmd(serial_bus_pkg::op_read, 1'b1, 12'h055, 8'h00));
endtask

// both requests in the same cycle, arbiter serialises them
task automatic concurrent_write_test();
	fork
		issue_cmd(0, make_cmd(serial_bus_pkg::op_write, 1'b0, 12'h200, 8'h3c));
		issue_cmd(1, make_cmd(serial_bus_pkg::op_write, 1'b1, 12'h201, 8'hc3));
	join
	issue_cmd(1, make_cmd(serial_bus_pkg::op_read, 1'b0, 12'h200, 8'h00));
	issue_cmd(0, make_cmd(serial_bus_pkg::op_read, 1'b1, 12'h201, 8'h00));
endtask

// idle opcodes with write-like fields, memory must stay as it was
task automatic idle_op_test();
	issue_cmd(0, make_cmd(2'd0, 1'b0, 12'h123, 8'hff));
	issue_cmd(1, make_cmd(2'd1, 1'b0, 12'h123, 8'hee));
	issue_cmd(1, make_cmd(serial_bus_pkg::op_read, 1'b0, 12'h123, 8'h00));
endtask

task automatic random_mix_test();
	logic [serial_bus_pkg::addr_len-1:0] pool [pool_size];
	serial_bus_pkg::cmd_t list_0 [$];
	serial_bus_pkg::cmd_t list_1 [$];
	serial_bus_pkg::cmd_t c;
	logic [31:0] r;
	pool = '{12'h010, 12'h3f0, 12'h800, 12'hfff};
	// pool written on both slaves first
	for (int s = 0; s < 2; s++) begin
		for (int k = 0; k < pool_size; k++) begin
			r = xorshift();
			issue_cmd(0, make_cmd(serial_bus_pkg::op_write, s[0], pool[k], r[7:0]));
		end
	end
	// lists built up front so the draw order is fixed
	for (int i = 0; i < 40; i++) begin
		r = xorshift();
		c = make_cmd(r[0] ? serial_bus_pkg::op_write : serial_bus_pkg::op_read, r[1],
			pool[r[3:2]], r[15:8]);
		if (i % 2 == 0)
			list_0.push_back(c);
		else
			list_1.push_back(c);
	end
	fork
		foreach (list_0[i])
			issue_cmd(0, list_0[i]);
		foreach (list_1[j])
			issue_cmd(1, list_1[j]);
	join
endtask

// File: verification/serial_bus_tb.sv
// serial bus testbench: clock, reset, DUT, reference memory model, watchdog and result line
module serial_bus_tb;

	// commands issued over all tests, sizes the watchdog
	localparam int n_cmds = 61;
	localparam int clk_period = 40;
	localparam int pool_size = 4;
	localparam int key_len = serial_bus_pkg::slave_len + serial_bus_pkg::addr_len;

	logic clk;
	logic arst_n;
	logic cmd_req_0;
	logic cmd_req_1;
	serial_bus_pkg::cmd_t cmd_0;
	serial_bus_pkg::cmd_t cmd_1;
	logic cmd_ack_0;
	logic cmd_ack_1;
	logic [serial_bus_pkg::data_len-1:0] rdata_0;
	logic [serial_bus_pkg::data_len-1:0] rdata_1;

	int errors;
	int checks;
	// xorshift state
	logic [31:0] rng_state;
	// expected memory contents, keyed by {slave, addr}
	logic [serial_bus_pkg::data_len-1:0] model [logic [key_len-1:0]];

	serial_bus_top serial_bus_top_i (
		.clk(clk),
		.arst_n(arst_n),
		.cmd_req_0(cmd_req_0),
		.cmd_req_1(cmd_req_1),
		.cmd_0(cmd_0),
		.cmd_1(cmd_1),
		.cmd_ack_0(cmd_ack_0),
		.cmd_ack_1(cmd_ack_1),
		.rdata_0(rdata_0),
		.rdata_1(rdata_1)
	);

	always #(clk_period / 2) clk = ~clk;

	`include "serial_bus_tasks.svh"

	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		cmd_req_0 = 1'b0;
		cmd_req_1 = 1'b0;
		cmd_0 = '0;
		cmd_1 = '0;
		errors = 0;
		checks = 0;
		rng_state = 32'h4e0e;
		// reset held for three cycles
		repeat (3) @(posedge clk);
		#2;
		arst_n = 1'b1;
		after_reset_test();
		select_decode_test();
		concurrent_write_test();
		idle_op_test();
		random_mix_test();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// generous bound per command plus reset and slack
	initial begin
		#(n_cmds * 60 * clk_period + 100 * clk_period);
		$display("timeout: a command was not acknowledged in time, run stopped");
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: sim.f
+incdir+verification
rtl/serial_bus_pkg.sv
rtl/master_out_port.sv
rtl/master_in_port.sv
rtl/master_port.sv
rtl/bus_arbiter.sv
rtl/slave_port.sv
rtl/serial_bus_top.sv
verification/serial_bus_tb.sv

// File: Makefile
TOP = serial_bus_tb
BIN = obj_dir/V$(TOP)
SRCS = $(shell grep -v '^+' sim.f) verification/serial_bus_tasks.svh

all: run

$(BIN): sim.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f sim.f -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -qx "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
